/* source/xvr_config.svh */
// register port configuration
// clock rate, tenth-millisecond divisor and synchroniser depth
`ifndef XVR_CONFIG_SVH
`define XVR_CONFIG_SVH

// pixel clock in Hz
`define XVR_PCLK_HZ         25000000

// fraction terminal count, one tick every DIV+1 clocks
`define XVR_TIMER_DIV       (`XVR_PCLK_HZ / 10000)

// fraction counter must hold XVR_TIMER_DIV
`define XVR_FRAC_W          12

// flops on each asynchronous host input
`define XVR_SYNC_STAGES     2

`endif

/* source/xvr_pkg.sv */
// register port types
// bus, word and address vectors plus the register number map
package xvr_pkg;

    typedef logic [7:0]  byte_t;            // host bus byte
    typedef logic [15:0] word_t;            // register / memory word
    typedef logic [15:0] addr_t;            // VRAM or XR word address
    typedef logic [3:0]  nibble_mask_t;     // VRAM nibble write enables

    // host visible register numbers, 11 to 15 unused
    typedef enum logic [3:0] {
        REG_SYS_CTRL = 4'd0,                // wait status, write mask
        REG_TIMER    = 4'd1,                // 0.1 ms tick count
        REG_RD_XADDR = 4'd2,                // XR read address
        REG_WR_XADDR = 4'd3,                // XR write address
        REG_XDATA    = 4'd4,                // XR data port
        REG_RD_INCR  = 4'd5,                // VRAM read step
        REG_RD_ADDR  = 4'd6,                // VRAM read address
        REG_WR_INCR  = 4'd7,                // VRAM write step
        REG_WR_ADDR  = 4'd8,                // VRAM write address
        REG_DATA     = 4'd9,                // VRAM data port
        REG_DATA_2   = 4'd10                // VRAM data port alias
    } reg_num_t;

endpackage

/* source/bus_sync_stage.sv */
// host bus synchroniser
// brings the asynchronous bus into clk and strobes once per chip select,
// with register number, byte select and data held until the next strobe
`timescale 1ns/1ps
`include "xvr_config.svh"

module bus_sync_stage (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            cs_n_i,             // chip select, low active
    input  logic            rd_nwr_i,           // 1 read, 0 write
    input  logic            bytesel_i,          // 0 even, 1 odd
    input  logic [3:0]      reg_num_i,
    input  xvr_pkg::byte_t  data_i,
    output logic            write_strobe_o,
    output logic            read_strobe_o,
    output logic            bytesel_o,
    output xvr_pkg::reg_num_t reg_num_o,
    output xvr_pkg::byte_t  data_o
);
    import xvr_pkg::*;

    localparam int N = `XVR_SYNC_STAGES;

    logic [N-1:0] cs_n_sync;                    // shifts toward msb
    logic [N-1:0] rd_nwr_sync;
    logic [N-1:0] bytesel_sync;
    logic [3:0]   reg_num_sync [N];
    byte_t        data_sync [N];
    logic         cs_n_last;                    // previous synced cs_n
    logic         cs_fall;

    assign cs_fall = cs_n_last & ~cs_n_sync[N-1];

    // cs path holds idle high through reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_sync <= '1;
            cs_n_last <= 1'b1;
        end else begin
            cs_n_sync <= {cs_n_sync[N-2:0], cs_n_i};
            cs_n_last <= cs_n_sync[N-1];
        end
    end

    always_ff @(posedge clk) begin
        rd_nwr_sync     <= {rd_nwr_sync[N-2:0], rd_nwr_i};
        bytesel_sync    <= {bytesel_sync[N-2:0], bytesel_i};
        reg_num_sync[0] <= reg_num_i;
        data_sync[0]    <= data_i;
        for (int i = 1; i < N; i++) begin
            reg_num_sync[i] <= reg_num_sync[i-1];
            data_sync[i]    <= data_sync[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            bytesel_o      <= 1'b0;
            reg_num_o      <= REG_SYS_CTRL;
        end else begin
            write_strobe_o <= cs_fall & ~rd_nwr_sync[N-1];
            read_strobe_o  <= cs_fall & rd_nwr_sync[N-1];
            if (cs_fall) begin
                bytesel_o <= bytesel_sync[N-1];
                reg_num_o <= reg_num_t'(reg_num_sync[N-1]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_fall) begin
            data_o <= data_sync[N-1];           // write byte payload
        end
    end

endmodule

/* source/mem_access_stage.sv */
// register file and memory request logic
// holds the writable registers, issues VRAM and XR reads, writes and
// prefetches, and steps the addresses when the access is acknowledged
`timescale 1ns/1ps

module mem_access_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    write_strobe_i,
    input  logic                    read_strobe_i,
    input  logic                    bytesel_i,
    input  xvr_pkg::reg_num_t       reg_num_i,
    input  xvr_pkg::byte_t          data_i,
    input  logic                    vram_ack_i,
    input  logic                    xr_ack_i,
    input  xvr_pkg::word_t          vram_data_i,
    input  xvr_pkg::word_t          xr_data_i,
    output logic                    vram_sel_o,
    output logic                    xr_sel_o,
    output logic                    wr_o,
    output xvr_pkg::nibble_mask_t   wrmask_o,
    output xvr_pkg::addr_t          addr_o,
    output xvr_pkg::word_t          data_o,
    output logic                    mem_wait_o,
    output xvr_pkg::addr_t          rd_xaddr_o,
    output xvr_pkg::addr_t          wr_xaddr_o,
    output xvr_pkg::addr_t          rd_addr_o,
    output xvr_pkg::addr_t          wr_addr_o,
    output xvr_pkg::word_t          xdata_o,
    output xvr_pkg::word_t          rd_incr_o,
    output xvr_pkg::word_t          wr_incr_o,
    output xvr_pkg::word_t          vram_data_o
);
    import xvr_pkg::*;

    logic  vram_rd;                             // VRAM read outstanding
    logic  xr_rd;                               // XR read outstanding
    byte_t data_even;                           // DATA high byte hold
    byte_t xdata_even;                          // XDATA high byte hold

    assign mem_wait_o = vram_sel_o | xr_sel_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o  <= 1'b0;
            xr_sel_o    <= 1'b0;
            wr_o        <= 1'b0;
            vram_rd     <= 1'b0;
            xr_rd       <= 1'b0;
            wrmask_o    <= 4'hF;
            addr_o      <= '0;
            data_o      <= '0;
            rd_xaddr_o  <= '0;
            wr_xaddr_o  <= '0;
            rd_addr_o   <= '0;
            wr_addr_o   <= '0;
            xdata_o     <= '0;
            rd_incr_o   <= '0;
            wr_incr_o   <= '0;
            vram_data_o <= '0;
            data_even   <= '0;
            xdata_even  <= '0;
        end else begin
            if (vram_ack_i) begin
                if (vram_rd) begin
                    vram_data_o <= vram_data_i;
                    rd_addr_o   <= rd_addr_o + rd_incr_o;
                end
                if (wr_o) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;
                end
                vram_sel_o <= 1'b0;
                wr_o       <= 1'b0;
                vram_rd    <= 1'b0;
            end

            if (xr_ack_i) begin
                if (xr_rd) begin
                    xdata_o    <= xr_data_i;
                    rd_xaddr_o <= rd_xaddr_o + 16'd1;
                end
                if (wr_o) begin
                    wr_xaddr_o <= wr_xaddr_o + 16'd1;
                end
                xr_sel_o <= 1'b0;
                wr_o     <= 1'b0;
                xr_rd    <= 1'b0;
            end

            // strobes come after the acks so a new request wins
            if (write_strobe_i) begin
                case (reg_num_i)
                    REG_SYS_CTRL: begin
                        if (bytesel_i) begin
                            wrmask_o <= data_i[3:0];
                        end
                    end
                    REG_RD_XADDR: begin
                        if (!bytesel_i) begin
                            rd_xaddr_o[15:8] <= data_i;
                        end else begin
                            rd_xaddr_o[7:0] <= data_i;
                            xr_sel_o        <= 1'b1;
                            xr_rd           <= 1'b1;
                            addr_o          <= {rd_xaddr_o[15:8], data_i};  // new address
                        end
                    end
                    REG_WR_XADDR: begin
                        if (!bytesel_i) begin
                            wr_xaddr_o[15:8] <= data_i;
                        end else begin
                            wr_xaddr_o[7:0] <= data_i;
                        end
                    end
                    REG_XDATA: begin
                        if (!bytesel_i) begin
                            xdata_even <= data_i;
                        end else begin
                            xr_sel_o <= 1'b1;
                            wr_o     <= 1'b1;
                            addr_o   <= wr_xaddr_o;
                            data_o   <= {xdata_even, data_i};
                        end
                    end
                    REG_RD_INCR: begin
                        if (!bytesel_i) begin
                            rd_incr_o[15:8] <= data_i;
                        end else begin
                            rd_incr_o[7:0] <= data_i;
                        end
                    end
                    REG_RD_ADDR: begin
                        if (!bytesel_i) begin
                            rd_addr_o[15:8] <= data_i;
                        end else begin
                            rd_addr_o[7:0] <= data_i;
                            vram_sel_o     <= 1'b1;
                            vram_rd        <= 1'b1;
                            addr_o         <= {rd_addr_o[15:8], data_i};
                        end
                    end
                    REG_WR_INCR: begin
                        if (!bytesel_i) begin
                            wr_incr_o[15:8] <= data_i;
                        end else begin
                            wr_incr_o[7:0] <= data_i;
                        end
                    end
                    REG_WR_ADDR: begin
                        if (!bytesel_i) begin
                            wr_addr_o[15:8] <= data_i;
                        end else begin
                            wr_addr_o[7:0] <= data_i;
                        end
                    end
                    REG_DATA, REG_DATA_2: begin
                        if (!bytesel_i) begin
                            data_even <= data_i;
                        end else begin
                            vram_sel_o <= 1'b1;
                            wr_o       <= 1'b1;
                            addr_o     <= wr_addr_o;
                            data_o     <= {data_even, data_i};
                        end
                    end
                    default: begin                  // timer and unused numbers
                    end
                endcase
            end

            // odd byte read of a data port fetches the next word
            if (read_strobe_i && bytesel_i) begin
                if (reg_num_i == REG_XDATA) begin
                    xr_sel_o <= 1'b1;
                    xr_rd    <= 1'b1;
                    addr_o   <= rd_xaddr_o;
                end
                if (reg_num_i == REG_DATA || reg_num_i == REG_DATA_2) begin
                    vram_sel_o <= 1'b1;
                    vram_rd    <= 1'b1;
                    addr_o     <= rd_addr_o;
                end
            end
        end
    end

endmodule

/* source/tenth_ms_timer.sv */
// tenth-millisecond timer
// free-running tick counter, one tick every XVR_TIMER_DIV+1 clocks
`timescale 1ns/1ps
`include "xvr_config.svh"

module tenth_ms_timer (
    input  logic            clk,
    input  logic            reset_i,
    output xvr_pkg::word_t  timer_o
);
    import xvr_pkg::*;

    logic [`XVR_FRAC_W-1:0] frac;               // clocks within the tick

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            timer_o <= '0;
        end else if (frac == `XVR_FRAC_W'(`XVR_TIMER_DIV)) begin
            frac    <= '0;
            timer_o <= timer_o + 16'd1;
        end else begin
            frac <= frac + 1'b1;
        end
    end

endmodule

/* source/read_back_stage.sv */
// register read-back
// picks the word for the latched register number and drives the
// selected byte, with the timer low byte frozen on each even read
`timescale 1ns/1ps

module read_back_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    read_strobe_i,
    input  logic                    bytesel_i,
    input  xvr_pkg::reg_num_t       reg_num_i,
    input  logic                    mem_wait_i,
    input  xvr_pkg::nibble_mask_t   wrmask_i,
    input  xvr_pkg::word_t          timer_i,
    input  xvr_pkg::addr_t          rd_xaddr_i,
    input  xvr_pkg::addr_t          wr_xaddr_i,
    input  xvr_pkg::addr_t          rd_addr_i,
    input  xvr_pkg::addr_t          wr_addr_i,
    input  xvr_pkg::word_t          xdata_i,
    input  xvr_pkg::word_t          rd_incr_i,
    input  xvr_pkg::word_t          wr_incr_i,
    input  xvr_pkg::word_t          vram_data_i,
    output xvr_pkg::byte_t          bus_data_o
);
    import xvr_pkg::*;

    byte_t timer_lo;                            // low byte at last even read
    word_t rd_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            timer_lo <= '0;
        end else if (read_strobe_i && !bytesel_i) begin
            timer_lo <= timer_i[7:0];
        end
    end

    always_comb begin
        case (reg_num_i)
            REG_SYS_CTRL:         rd_word = {mem_wait_i, 11'b0, wrmask_i};
            REG_TIMER:            rd_word = {timer_i[15:8], timer_lo};
            REG_RD_XADDR:         rd_word = rd_xaddr_i;
            REG_WR_XADDR:         rd_word = wr_xaddr_i;
            REG_XDATA:            rd_word = xdata_i;
            REG_RD_INCR:          rd_word = rd_incr_i;
            REG_RD_ADDR:          rd_word = rd_addr_i;
            REG_WR_INCR:          rd_word = wr_incr_i;
            REG_WR_ADDR:          rd_word = wr_addr_i;
            REG_DATA, REG_DATA_2: rd_word = vram_data_i;
            default:              rd_word = '0;     // unused numbers
        endcase
    end

    assign bus_data_o = bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

/* source/reg_interface.sv */
// video controller host register port
// bus synchroniser, register and memory access, timer and read-back
`timescale 1ns/1ps

module reg_interface (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    bus_cs_n_i,
    input  logic                    bus_rd_nwr_i,
    input  logic                    bus_bytesel_i,
    input  logic [3:0]              bus_reg_num_i,
    input  xvr_pkg::byte_t          bus_data_i,
    output xvr_pkg::byte_t          bus_data_o,
    input  logic                    vram_ack_i,
    input  logic                    xr_ack_i,
    output logic                    vram_sel_o,
    output logic                    xr_sel_o,
    output logic                    wr_o,
    output xvr_pkg::nibble_mask_t   wrmask_o,
    output xvr_pkg::addr_t          addr_o,
    output xvr_pkg::word_t          data_o,
    input  xvr_pkg::word_t          vram_data_i,
    input  xvr_pkg::word_t          xr_data_i
);
    import xvr_pkg::*;

    logic     write_strobe;
    logic     read_strobe;
    logic     bytesel;
    reg_num_t reg_num;
    byte_t    bus_byte;                         // synced write byte
    logic     mem_wait;
    addr_t    rd_xaddr;
    addr_t    wr_xaddr;
    addr_t    rd_addr;
    addr_t    wr_addr;
    word_t    xdata;
    word_t    rd_incr;
    word_t    wr_incr;
    word_t    vram_data;
    word_t    timer;

    bus_sync_stage u_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .cs_n_i         (bus_cs_n_i),
        .rd_nwr_i       (bus_rd_nwr_i),
        .bytesel_i      (bus_bytesel_i),
        .reg_num_i      (bus_reg_num_i),
        .data_i         (bus_data_i),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .bytesel_o      (bytesel),
        .reg_num_o      (reg_num),
        .data_o         (bus_byte)
    );

    mem_access_stage u_mem (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .bytesel_i      (bytesel),
        .reg_num_i      (reg_num),
        .data_i         (bus_byte),
        .vram_ack_i     (vram_ack_i),
        .xr_ack_i       (xr_ack_i),
        .vram_data_i    (vram_data_i),
        .xr_data_i      (xr_data_i),
        .vram_sel_o     (vram_sel_o),
        .xr_sel_o       (xr_sel_o),
        .wr_o           (wr_o),
        .wrmask_o       (wrmask_o),
        .addr_o         (addr_o),
        .data_o         (data_o),
        .mem_wait_o     (mem_wait),
        .rd_xaddr_o     (rd_xaddr),
        .wr_xaddr_o     (wr_xaddr),
        .rd_addr_o      (rd_addr),
        .wr_addr_o      (wr_addr),
        .xdata_o        (xdata),
        .rd_incr_o      (rd_incr),
        .wr_incr_o      (wr_incr),
        .vram_data_o    (vram_data)
    );

    tenth_ms_timer u_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .timer_o (timer)
    );

    read_back_stage u_rdback (
        .clk           (clk),
        .reset_i       (reset_i),
        .read_strobe_i (read_strobe),
        .bytesel_i     (bytesel),
        .reg_num_i     (reg_num),
        .mem_wait_i    (mem_wait),
        .wrmask_i      (wrmask_o),
        .timer_i       (timer),
        .rd_xaddr_i    (rd_xaddr),
        .wr_xaddr_i    (wr_xaddr),
        .rd_addr_i     (rd_addr),
        .wr_addr_i     (wr_addr),
        .xdata_i       (xdata),
        .rd_incr_i     (rd_incr),
        .wr_incr_i     (wr_incr),
        .vram_data_i   (vram_data),
        .bus_data_o    (bus_data_o)
    );

endmodule

/* verif/reg_interface_asserts.sv */
// memory request checks for the register and memory access stage
// select exclusion, write qualifier, strobe exclusion, select release on ack
`timescale 1ns/1ps

module reg_interface_asserts (
    input logic clk,
    input logic reset_i,
    input logic write_strobe_i,
    input logic read_strobe_i,
    input logic vram_sel_i,
    input logic xr_sel_i,
    input logic wr_i,
    input logic vram_ack_i,
    input logic xr_ack_i
);

    int fail_count = 0;

    one_select: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_i && xr_sel_i))
        else begin
            $error("VRAM and XR selects high together");
            fail_count++;
        end

    wr_with_select: assert property (@(posedge clk) disable iff (reset_i)
        wr_i |-> (vram_sel_i || xr_sel_i))
        else begin
            $error("wr_o high without a select");
            fail_count++;
        end

    one_strobe: assert property (@(posedge clk) disable iff (reset_i)
        !(write_strobe_i && read_strobe_i))
        else begin
            $error("read and write strobes high together");
            fail_count++;
        end

    vram_release: assert property (@(posedge clk) disable iff (reset_i)
        vram_ack_i |=> !vram_sel_i)
        else begin
            $error("vram_sel_o still high after its ack");
            fail_count++;
        end

    xr_release: assert property (@(posedge clk) disable iff (reset_i)
        xr_ack_i |=> !xr_sel_i)
        else begin
            $error("xr_sel_o still high after its ack");
            fail_count++;
        end

endmodule

bind mem_access_stage reg_interface_asserts u_asserts (
    .clk            (clk),
    .reset_i        (reset_i),
    .write_strobe_i (write_strobe_i),
    .read_strobe_i  (read_strobe_i),
    .vram_sel_i     (vram_sel_o),
    .xr_sel_i       (xr_sel_o),
    .wr_i           (wr_o),
    .vram_ack_i     (vram_ack_i),
    .xr_ack_i       (xr_ack_i)
);

/* verif/reg_interface_tb.sv */
// testbench for the host register port
// asynchronous bus tasks, VRAM and XR memory models, directed tests, watchdog
`timescale 1ns/1ps
`include "xvr_config.svh"

module reg_interface_tb;
    import xvr_pkg::*;

    localparam int  TICK        = `XVR_TIMER_DIV + 1;   // clocks per timer tick
    localparam time WATCHDOG_NS = 8 * TICK * 20;        // timer test takes about four ticks

    logic         clk;
    logic         reset_i;
    logic         bus_cs_n;
    logic         bus_rd_nwr;
    logic         bus_bytesel;
    logic [3:0]   bus_reg_num;
    byte_t        bus_wdata;
    byte_t        bus_rdata;
    logic         vram_ack;
    logic         xr_ack;
    logic         vram_sel;
    logic         xr_sel;
    logic         wr;
    nibble_mask_t wrmask;
    addr_t        addr;
    word_t        wdata;
    word_t        vram_rdata;
    word_t        xr_rdata;

    word_t        vram_mem  [0:65535];
    nibble_mask_t vram_mask [0:65535];                  // mask of last write per word
    word_t        xr_mem    [0:65535];
    integer       seed = 32'haedb;
    int           vram_delay = 0;                       // 0 means random latency
    int           vram_lat;
    int           xr_lat;
    int           errors = 0;
    int           tests = 0;

    reg_interface uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_bytesel_i (bus_bytesel),
        .bus_reg_num_i (bus_reg_num),
        .bus_data_i    (bus_wdata),
        .bus_data_o    (bus_rdata),
        .vram_ack_i    (vram_ack),
        .xr_ack_i      (xr_ack),
        .vram_sel_o    (vram_sel),
        .xr_sel_o      (xr_sel),
        .wr_o          (wr),
        .wrmask_o      (wrmask),
        .addr_o        (addr),
        .data_o        (wdata),
        .vram_data_i   (vram_rdata),
        .xr_data_i     (xr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // VRAM model, ack 1 to 4 cycles after the select
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (vram_sel) begin
                vram_lat = (vram_delay != 0) ? vram_delay : 1 + $unsigned($random(seed)) % 4;
                repeat (vram_lat) @(posedge clk);
                #2;
                if (wr) begin
                    vram_mem[addr]  = wdata;
                    vram_mask[addr] = wrmask;
                end else begin
                    vram_rdata = vram_mem[addr];
                end
                vram_ack = 1'b1;
                @(posedge clk);
                #2;
                vram_ack = 1'b0;
            end
        end
    end

    // XR model, same timing without a mask
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (xr_sel) begin
                xr_lat = 1 + $unsigned($random(seed)) % 4;
                repeat (xr_lat) @(posedge clk);
                #2;
                if (wr) begin
                    xr_mem[addr] = wdata;
                end else begin
                    xr_rdata = xr_mem[addr];
                end
                xr_ack = 1'b1;
                @(posedge clk);
                #2;
                xr_ack = 1'b0;
            end
        end
    end

    task automatic report_mismatch(input string test, input word_t expected,
                                   input word_t actual);
        errors++;
        $display("ERROR %s: expected %h, actual %h", test, expected, actual);
    endtask

    // cs_n low 6 cycles then high 4, read sampled mid 6th low cycle
    task automatic bus_cycle(input logic rd, input logic [3:0] num, input logic odd,
                             input byte_t wbyte, output byte_t rbyte);
        @(posedge clk);
        #2;
        bus_rd_nwr  = rd;
        bus_reg_num = num;
        bus_bytesel = odd;
        bus_wdata   = wbyte;
        bus_cs_n    = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rbyte = bus_rdata;
        @(posedge clk);
        #2;
        bus_cs_n = 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic write_reg(input logic [3:0] num, input word_t w);
        byte_t dummy;
        bus_cycle(1'b0, num, 1'b0, w[15:8], dummy);
        bus_cycle(1'b0, num, 1'b1, w[7:0], dummy);
        wait (!vram_sel && !xr_sel);                    // host honours mem_wait
    endtask

    task automatic write_odd(input logic [3:0] num, input byte_t b);
        byte_t dummy;
        bus_cycle(1'b0, num, 1'b1, b, dummy);
    endtask

    task automatic read_reg(input logic [3:0] num, output word_t w);
        byte_t hi;
        byte_t lo;
        bus_cycle(1'b1, num, 1'b0, 8'h00, hi);
        bus_cycle(1'b1, num, 1'b1, 8'h00, lo);
        w = {hi, lo};
        wait (!vram_sel && !xr_sel);
    endtask

    task automatic test_readback();
        logic [3:0] nums [4];
        word_t      vals [4];
        word_t      got;
        nums = '{REG_RD_INCR, REG_WR_INCR, REG_WR_ADDR, REG_WR_XADDR};
        vals = '{16'h0102, 16'h0304, 16'h1234, 16'h0a55};
        for (int i = 0; i < 4; i++) begin
            write_reg(nums[i], vals[i]);
            read_reg(nums[i], got);
            if (got !== vals[i]) report_mismatch("readback", vals[i], got);
        end
        write_odd(REG_SYS_CTRL, 8'h05);
        read_reg(REG_SYS_CTRL, got);
        if (got !== 16'h0005) report_mismatch("readback sys_ctrl", 16'h0005, got);
        write_reg(4'd12, 16'hbeef);
        read_reg(4'd12, got);
        if (got !== 16'h0000) report_mismatch("readback unused", 16'h0000, got);
        tests++;
    endtask

    task automatic test_vram_write();
        addr_t base;
        word_t step;
        addr_t a;
        word_t exp;
        word_t got;
        base = 16'h0100;
        step = 16'h0003;
        write_reg(REG_WR_ADDR, base);
        write_reg(REG_WR_INCR, step);
        write_odd(REG_SYS_CTRL, 8'h06);
        for (int k = 0; k < 6; k++) begin
            exp = 16'ha000 + 16'(k) * 16'h0111;
            write_reg((k % 2) ? REG_DATA_2 : REG_DATA, exp);
        end
        for (int k = 0; k < 6; k++) begin
            a   = base + 16'(k) * step;
            exp = 16'ha000 + 16'(k) * 16'h0111;
            if (vram_mem[a] !== exp) report_mismatch("vram write data", exp, vram_mem[a]);
            if (vram_mask[a] !== 4'h6) begin
                report_mismatch("vram write mask", 16'h0006, {12'h000, vram_mask[a]});
            end
        end
        read_reg(REG_WR_ADDR, got);
        exp = base + 16'd6 * step;
        if (got !== exp) report_mismatch("vram write addr", exp, got);
        tests++;
    endtask

    task automatic test_vram_read();
        addr_t base;
        word_t step;
        word_t exp;
        word_t got;
        base = 16'h2000;
        step = 16'h0005;
        for (int k = 0; k < 6; k++) begin
            vram_mem[base + 16'(k) * step] = 16'h5a00 ^ (16'(k) * 16'h1357);
        end
        write_reg(REG_RD_INCR, step);
        write_reg(REG_RD_ADDR, base);
        for (int k = 0; k < 5; k++) begin
            read_reg(REG_DATA, got);
            exp = 16'h5a00 ^ (16'(k) * 16'h1357);
            if (got !== exp) report_mismatch("vram read data", exp, got);
        end
        read_reg(REG_RD_ADDR, got);
        exp = base + 16'd6 * step;                      // five read plus one prefetched
        if (got !== exp) report_mismatch("vram read addr", exp, got);
        tests++;
    endtask

    task automatic test_xr();
        addr_t base;
        word_t exp;
        word_t got;
        base = 16'h0040;
        write_reg(REG_WR_XADDR, base);
        for (int k = 0; k < 4; k++) begin
            write_reg(REG_XDATA, 16'h3c00 + 16'(k) * 16'h0101);
        end
        for (int k = 0; k < 4; k++) begin
            exp = 16'h3c00 + 16'(k) * 16'h0101;
            if (xr_mem[base + 16'(k)] !== exp) begin
                report_mismatch("xr write data", exp, xr_mem[base + 16'(k)]);
            end
        end
        read_reg(REG_WR_XADDR, got);
        if (got !== base + 16'd4) report_mismatch("xr write addr", base + 16'd4, got);
        write_reg(REG_RD_XADDR, base);
        for (int k = 0; k < 4; k++) begin
            read_reg(REG_XDATA, got);
            exp = 16'h3c00 + 16'(k) * 16'h0101;
            if (got !== exp) report_mismatch("xr read data", exp, got);
        end
        read_reg(REG_RD_XADDR, got);
        if (got !== base + 16'd5) report_mismatch("xr read addr", base + 16'd5, got);
        tests++;
    endtask

    task automatic test_timer();
        word_t t1;
        word_t t2;
        word_t diff;
        byte_t hi;
        byte_t lo;
        byte_t exp_lo;
        byte_t delta;
        time   t_first;
        time   t_even;
        int    elapsed;
        t_first = $time;
        read_reg(REG_TIMER, t1);
        repeat (3 * TICK) @(posedge clk);
        read_reg(REG_TIMER, t2);
        diff = t2 - t1;
        if (diff < 16'd2 || diff > 16'd4) report_mismatch("timer step", 16'd3, diff);
        t_even = $time;
        bus_cycle(1'b1, REG_TIMER, 1'b0, 8'h00, hi);
        repeat (TICK) @(posedge clk);                   // live low byte moves on
        bus_cycle(1'b1, REG_TIMER, 1'b1, 8'h00, lo);
        elapsed = int'((t_even - t_first) / (20 * TICK));
        exp_lo  = t1[7:0] + 8'(elapsed);
        delta   = lo - exp_lo;
        if (delta != 8'h00 && delta != 8'h01 && delta != 8'hff) begin
            report_mismatch("timer latch", {8'h00, exp_lo}, {8'h00, lo});
        end
        tests++;
    endtask

    task automatic test_busy();
        byte_t dummy;
        word_t got;
        vram_delay = 40;
        bus_cycle(1'b0, REG_DATA, 1'b0, 8'h77, dummy);
        bus_cycle(1'b0, REG_DATA, 1'b1, 8'h77, dummy);
        read_reg(REG_SYS_CTRL, got);                    // ack still far away
        if (got !== 16'h8006) report_mismatch("busy set", 16'h8006, got);
        vram_delay = 0;
        read_reg(REG_SYS_CTRL, got);
        if (got !== 16'h0006) report_mismatch("busy clear", 16'h0006, got);
        tests++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset_i     = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_bytesel = 1'b0;
        bus_reg_num = 4'd0;
        bus_wdata   = 8'h00;
        vram_ack    = 1'b0;
        xr_ack      = 1'b0;
        vram_rdata  = 16'h0000;
        xr_rdata    = 16'h0000;
        for (int i = 0; i < 65536; i++) begin
            vram_mem[i] = 16'(i * 40503) ^ 16'h1234;    // odd multiplier, unique words
            xr_mem[i]   = 16'(i * 27) ^ 16'hc3a5;
        end
        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;

        test_readback();
        test_vram_write();
        test_vram_read();
        test_xr();
        test_timer();
        test_busy();

        $display("tests run: %0d, errors: %0d, assertion failures: %0d",
                 tests, errors, uut.u_mem.u_asserts.fail_count);
        if (errors == 0 && uut.u_mem.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* reg_interface.f */
+incdir+source
source/xvr_pkg.sv
source/bus_sync_stage.sv
source/mem_access_stage.sv
source/tenth_ms_timer.sv
source/read_back_stage.sv
source/reg_interface.sv
verif/reg_interface_asserts.sv
verif/reg_interface_tb.sv
